//--- verification/program_input.hex
// Word 0 program length, then the program words from the reset PC,
// then the store count, then expected store address and data pairs
0000007D
FF900093 00300113 123451B7 00001217 FFA0A793 // addi x1 -7, addi x2 3, lui, auipc, slti
002082B3 40110333 002113B3 0020A433 0020B4B3 // add sub sll slt sltu
0020C533 0020D5B3 4020D633 0020E6B3 0020F733 // xor srl sra or and
10302023 10402223 10502423 10602623 10702823 // stores x3..x7
10802A23 10902C23 10A02E23 12B02023 12C02223 // stores x8..x12
12D02423 12E02623 FFF13813 FFF0C893 4010D913 // stores x13 x14, sltiu xori srai
00411993 01C0DA13 10016A93 0F00FB13 00508013 // slli srli ori andi, addi to x0
12F02823 13002A23 13102C23 13202E23 15302023 // stores x15..x19
15402223 15502423 15602623 14002823 00210A63 // stores x20 x21 x22 x0, beq taken
00000013 00000013 22202023 3E102823 00208A63 // slot store, skipped store, beq not taken
00000013 00000013 00000013 20202023 00209A63 // fall-through store, bne taken
00000013 00000013 00000013 3E102823 00211A63 // skipped, bne not taken
00000013 00000013 00000013 20202223 0020CA63 // fall-through, blt taken
00000013 00000013 00000013 3E102823 00114A63 // skipped, blt not taken
00000013 00000013 00000013 20202423 00115A63 // fall-through, bge taken
00000013 00000013 00000013 3E102823 0020DA63 // skipped, bge not taken
00000013 00000013 00000013 20202623 00116A63 // fall-through, bltu taken
00000013 00000013 00000013 3E102823 0020EA63 // skipped, bltu not taken
00000013 00000013 00000013 20202823 0020FA63 // fall-through, bgeu taken
00000013 00000013 00000013 3E102823 00117A63 // skipped, bgeu not taken
00000013 00000013 00000013 20202A23 01400BEF // fall-through, jal x23
00000013 00000013 00000013 3E102823 23702823 // skipped, store link x23
00000C17 00000013 00000013 00000013 025C0CE7 // auipc x24, jalr x25 with odd offset
00000013 00000013 00000013 3E102823 23902A23 // skipped, store link x25
10002D03 00000013 00000013 00000013 31A02023 // lw x26, store it again
0000001F
00000100 12345000 00000104 0001100C
00000108 FFFFFFFC 0000010C 0000000A
00000110 00000018 00000114 00000001
00000118 00000000 0000011C FFFFFFFA
00000120 1FFFFFFF 00000124 FFFFFFFF
00000128 FFFFFFFB 0000012C 00000001
00000130 00000001 00000134 00000001
00000138 00000006 0000013C FFFFFFFC
00000140 00000030 00000144 0000000F
00000148 00000103 0000014C 000000F0
00000150 00000000 00000220 00000003
00000200 00000003 00000204 00000003
00000208 00000003 0000020C 00000003
00000210 00000003 00000214 00000003
00000230 000101A4 00000234 000101CC
00000300 12345000

//--- build.f
+incdir+src
src/rv_isa_pkg.sv
src/rv_pipe_pkg.sv
src/fetch_unit.sv
src/decoder.sv
src/register_file.sv
src/execute_unit.sv
src/memory_access.sv
src/rv_pipeline_top.sv
verification/rv_pipeline_tb.sv

//--- Bender.yml
package:
  name: rv_pipeline

sources:
  - include_dirs:
      - src
    files:
      - src/rv_isa_pkg.sv
      - src/rv_pipe_pkg.sv
      - src/fetch_unit.sv
      - src/decoder.sv
      - src/register_file.sv
      - src/execute_unit.sv
      - src/memory_access.sv
      - src/rv_pipeline_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/rv_pipeline_tb.sv

//--- verification/rv_pipeline_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_params.svh"

module rv_pipeline_tb;

    localparam int          CLK_PERIOD   = 40;
    localparam int          RESET_CYCLES = 5;
    localparam int          INPUT_WORDS  = 256;
    localparam int          PROG_WORDS   = 128;
    localparam int          DMEM_WORDS   = 256;
    localparam int          MAX_STORES   = 64;
    localparam logic [31:0] NOP          = 32'h0000_0013; // addi x0, x0, 0

    logic                clk;
    logic                reset;
    logic [`RV_XLEN-1:0] iad;
    logic [`RV_XLEN-1:0] idt;
    logic [`RV_XLEN-1:0] dad;
    logic [`RV_XLEN-1:0] wdata;
    logic [`RV_XLEN-1:0] rdata;
    logic                mreq;
    logic                write;

    logic [31:0] input_words [0:INPUT_WORDS-1];
    logic [31:0] prog [0:PROG_WORDS-1];
    logic [31:0] dmem [0:DMEM_WORDS-1];
    logic [31:0] exp_addr [0:MAX_STORES-1];
    logic [31:0] exp_data [0:MAX_STORES-1];
    logic [31:0] imem_index;
    int          prog_len = 0;
    int          store_count = 0;
    int          stores_seen = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    rv_pipeline_top rv_pipeline_top_inst (
        .clk(clk), .reset(reset),
        .iad(iad), .idt(idt),
        .dad(dad), .wdata(wdata), .rdata(rdata),
        .mreq(mreq), .write(write)
    );

    // Program based at the reset PC, NOP outside it
    always_comb begin
        imem_index = (iad - `RV_RESET_PC) >> 2;
        if ($isunknown(iad) || iad < `RV_RESET_PC || imem_index >= prog_len) begin
            idt = NOP;
        end else begin
            idt = prog[imem_index[6:0]];
        end
    end

    always_comb begin
        if (mreq !== 1'b1 || $isunknown(dad)) begin
            rdata = '0; // Data only while a request is open
        end else begin
            rdata = dmem[dad[9:2]];
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic load_stimulus();
        $readmemh("verification/program_input.hex", input_words);
        if ($isunknown(input_words[0]) || input_words[0] > PROG_WORDS) begin
            $display("Stimulus file is missing or holds a bad program length");
            $display("*** FAILED ***");
            $fatal(1, "No usable stimulus");
        end
        prog_len = input_words[0];
        for (int k = 0; k < prog_len; k++) begin
            prog[k] = input_words[1 + k];
        end
        store_count = input_words[prog_len + 1];
        for (int k = 0; k < store_count; k++) begin
            exp_addr[k] = input_words[prog_len + 2 + 2 * k];
            exp_data[k] = input_words[prog_len + 3 + 2 * k];
        end
        cycle_limit = 4 * (prog_len + 20);
    endtask

    // Stores are checked in program order
    always @(posedge clk) begin
        if (!reset && mreq && write) begin
            if (stores_seen >= store_count) begin
                $display("Store to %h seen after the expected list ran out", dad);
                $display("*** FAILED ***");
                $fatal(1, "Unexpected store");
            end
            check_value($sformatf("store %0d address", stores_seen), exp_addr[stores_seen], dad);
            check_value($sformatf("store %0d data", stores_seen), exp_data[stores_seen], wdata);
            dmem[dad[9:2]] <= wdata;
            stores_seen    <= stores_seen + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Run timed out after %0d cycles with %0d of %0d stores seen",
                     cycle_count, stores_seen, store_count);
            $display("*** FAILED ***");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        for (int k = 0; k < DMEM_WORDS; k++) begin
            dmem[k] = k * 4; // Word holds its own byte address
        end
        load_stimulus();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        wait (stores_seen == store_count);
        $display("All %0d stores matched", store_count);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/rv_pipeline_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_params.svh"

module rv_pipeline_top (
    input  logic                clk,
    input  logic                reset,
    output logic [`RV_XLEN-1:0] iad,
    input  logic [`RV_XLEN-1:0] idt,
    output logic [`RV_XLEN-1:0] dad,
    output logic [`RV_XLEN-1:0] wdata,
    input  logic [`RV_XLEN-1:0] rdata,
    output logic                mreq,
    output logic                write
);

    import rv_pipe_pkg::*;

    logic                      redirect;
    logic [`RV_XLEN-1:0]       target;
    logic [`RV_XLEN-1:0]       id_pc, id_pc4, id_ir;
    logic                      id_valid;
    logic [`RV_REG_ADDR_W-1:0] rs1_addr, rs2_addr;
    logic [`RV_XLEN-1:0]       rs1_data, rs2_data;
    logic [`RV_XLEN-1:0]       ex_pc, ex_pc4, ex_a, ex_b, ex_imm;
    logic [ALU_OP_W-1:0]       ex_alu_op;
    logic                      ex_use_imm, ex_use_pc, ex_branch, ex_jump, ex_jalr;
    logic [2:0]                ex_funct3;
    logic                      ex_load, ex_store, ex_reg_write;
    logic [WB_SEL_W-1:0]       ex_wb_sel;
    logic [`RV_REG_ADDR_W-1:0] ex_rd;
    logic [`RV_XLEN-1:0]       mem_result, mem_store_data, mem_pc4;
    logic                      mem_load, mem_store, mem_reg_write;
    logic [WB_SEL_W-1:0]       mem_wb_sel;
    logic [`RV_REG_ADDR_W-1:0] mem_rd;
    logic                      wb_we;
    logic [`RV_REG_ADDR_W-1:0] wb_addr;
    logic [`RV_XLEN-1:0]       wb_data;

    fetch_unit fetch_unit_inst (
        .clk(clk), .reset(reset),
        .redirect(redirect), .target(target),
        .idt(idt), .iad(iad),
        .id_pc(id_pc), .id_pc4(id_pc4), .id_ir(id_ir), .id_valid(id_valid)
    );

    decoder decoder_inst (
        .clk(clk), .reset(reset),
        .id_valid(id_valid), .id_pc(id_pc), .id_pc4(id_pc4), .id_ir(id_ir),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .ex_pc(ex_pc), .ex_pc4(ex_pc4), .ex_a(ex_a), .ex_b(ex_b), .ex_imm(ex_imm),
        .ex_alu_op(ex_alu_op), .ex_use_imm(ex_use_imm), .ex_use_pc(ex_use_pc),
        .ex_branch(ex_branch), .ex_jump(ex_jump), .ex_jalr(ex_jalr),
        .ex_funct3(ex_funct3), .ex_load(ex_load), .ex_store(ex_store),
        .ex_reg_write(ex_reg_write), .ex_wb_sel(ex_wb_sel), .ex_rd(ex_rd)
    );

    register_file register_file_inst (
        .clk(clk), .reset(reset),
        .we(wb_we), .wr_addr(wb_addr), .wr_data(wb_data),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    execute_unit execute_unit_inst (
        .clk(clk), .reset(reset),
        .ex_pc(ex_pc), .ex_pc4(ex_pc4), .ex_a(ex_a), .ex_b(ex_b), .ex_imm(ex_imm),
        .ex_alu_op(ex_alu_op), .ex_use_imm(ex_use_imm), .ex_use_pc(ex_use_pc),
        .ex_branch(ex_branch), .ex_jump(ex_jump), .ex_jalr(ex_jalr),
        .ex_funct3(ex_funct3), .ex_load(ex_load), .ex_store(ex_store),
        .ex_reg_write(ex_reg_write), .ex_wb_sel(ex_wb_sel), .ex_rd(ex_rd),
        .redirect(redirect), .target(target),
        .mem_result(mem_result), .mem_store_data(mem_store_data), .mem_pc4(mem_pc4),
        .mem_load(mem_load), .mem_store(mem_store), .mem_reg_write(mem_reg_write),
        .mem_wb_sel(mem_wb_sel), .mem_rd(mem_rd)
    );

    memory_access memory_access_inst (
        .clk(clk), .reset(reset),
        .mem_result(mem_result), .mem_store_data(mem_store_data), .mem_pc4(mem_pc4),
        .mem_load(mem_load), .mem_store(mem_store), .mem_reg_write(mem_reg_write),
        .mem_wb_sel(mem_wb_sel), .mem_rd(mem_rd),
        .rdata(rdata), .dad(dad), .wdata(wdata), .mreq(mreq), .write(write),
        .wb_we(wb_we), .wb_addr(wb_addr), .wb_data(wb_data)
    );

endmodule

`default_nettype wire

//--- src/memory_access.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_params.svh"

module memory_access (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [`RV_XLEN-1:0]               mem_result,
    input  logic [`RV_XLEN-1:0]               mem_store_data,
    input  logic [`RV_XLEN-1:0]               mem_pc4,
    input  logic                              mem_load,
    input  logic                              mem_store,
    input  logic                              mem_reg_write,
    input  logic [rv_pipe_pkg::WB_SEL_W-1:0]  mem_wb_sel,
    input  logic [`RV_REG_ADDR_W-1:0]         mem_rd,
    input  logic [`RV_XLEN-1:0]               rdata,
    output logic [`RV_XLEN-1:0]               dad,
    output logic [`RV_XLEN-1:0]               wdata,
    output logic                              mreq,
    output logic                              write,
    output logic                              wb_we,
    output logic [`RV_REG_ADDR_W-1:0]         wb_addr,
    output logic [`RV_XLEN-1:0]               wb_data
);

    import rv_pipe_pkg::*;

    logic [`RV_XLEN-1:0] wb_value;

    assign dad   = mem_result;      // Effective address from the ALU
    assign wdata = mem_store_data;
    assign mreq  = mem_load | mem_store;
    assign write = mem_store;

    always_comb begin
        case (mem_wb_sel)
            WB_MEM:  wb_value = rdata;
            WB_PC4:  wb_value = mem_pc4;
            default: wb_value = mem_result;
        endcase
    end

    // MEM/WB
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_we <= 1'b0;
        end else begin
            wb_we <= mem_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        wb_addr <= mem_rd;
        wb_data <= wb_value;
    end

endmodule

`default_nettype wire

//--- src/execute_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_params.svh"

module execute_unit (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [`RV_XLEN-1:0]               ex_pc,
    input  logic [`RV_XLEN-1:0]               ex_pc4,
    input  logic [`RV_XLEN-1:0]               ex_a,
    input  logic [`RV_XLEN-1:0]               ex_b,
    input  logic [`RV_XLEN-1:0]               ex_imm,
    input  logic [rv_pipe_pkg::ALU_OP_W-1:0]  ex_alu_op,
    input  logic                              ex_use_imm,
    input  logic                              ex_use_pc,
    input  logic                              ex_branch,
    input  logic                              ex_jump,
    input  logic                              ex_jalr,
    input  logic [2:0]                        ex_funct3,
    input  logic                              ex_load,
    input  logic                              ex_store,
    input  logic                              ex_reg_write,
    input  logic [rv_pipe_pkg::WB_SEL_W-1:0]  ex_wb_sel,
    input  logic [`RV_REG_ADDR_W-1:0]         ex_rd,
    output logic                              redirect,
    output logic [`RV_XLEN-1:0]               target,
    output logic [`RV_XLEN-1:0]               mem_result,
    output logic [`RV_XLEN-1:0]               mem_store_data,
    output logic [`RV_XLEN-1:0]               mem_pc4,
    output logic                              mem_load,
    output logic                              mem_store,
    output logic                              mem_reg_write,
    output logic [rv_pipe_pkg::WB_SEL_W-1:0]  mem_wb_sel,
    output logic [`RV_REG_ADDR_W-1:0]         mem_rd
);

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic [`RV_XLEN-1:0] op_a, op_b, result, jump_target;
    logic [4:0]          shamt;
    logic                taken;

    assign op_a  = ex_use_pc ? ex_pc : ex_a;
    assign op_b  = ex_use_imm ? ex_imm : ex_b;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ex_alu_op)
            ALU_ADD:    result = op_a + op_b;
            ALU_SUB:    result = op_a - op_b;
            ALU_SLL:    result = op_a << shamt;
            ALU_SLT:    result = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   result = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:    result = op_a ^ op_b;
            ALU_SRL:    result = op_a >> shamt;
            ALU_SRA:    result = $signed(op_a) >>> shamt;
            ALU_OR:     result = op_a | op_b;
            ALU_AND:    result = op_a & op_b;
            ALU_PASS_B: result = op_b;
            default:    result = '0;
        endcase
    end

    // Branches always compare the two registers
    always_comb begin
        case (ex_funct3)
            F3_BEQ:  taken = ex_a == ex_b;
            F3_BNE:  taken = ex_a != ex_b;
            F3_BLT:  taken = $signed(ex_a) < $signed(ex_b);
            F3_BGE:  taken = $signed(ex_a) >= $signed(ex_b);
            F3_BLTU: taken = ex_a < ex_b;
            F3_BGEU: taken = ex_a >= ex_b;
            default: taken = 1'b0;
        endcase
    end

    assign jump_target = ex_jalr ? ((ex_a + ex_imm) & ~`RV_XLEN'd1) : ex_pc + ex_imm;

    // EX/MEM control
    always_ff @(posedge clk) begin
        if (reset) begin
            redirect      <= 1'b0;
            mem_load      <= 1'b0;
            mem_store     <= 1'b0;
            mem_reg_write <= 1'b0;
            mem_wb_sel    <= WB_ALU;
        end else begin
            redirect      <= ex_jump | (ex_branch & taken);
            mem_load      <= ex_load;
            mem_store     <= ex_store;
            mem_reg_write <= ex_reg_write;
            mem_wb_sel    <= ex_wb_sel;
        end
    end

    always_ff @(posedge clk) begin
        target         <= jump_target;
        mem_result     <= result;
        mem_store_data <= ex_b;
        mem_pc4        <= ex_pc4;
        mem_rd         <= ex_rd;
    end

endmodule

`default_nettype wire

//--- src/register_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_params.svh"

module register_file (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      we,
    input  logic [`RV_REG_ADDR_W-1:0] wr_addr,
    input  logic [`RV_XLEN-1:0]       wr_data,
    input  logic [`RV_REG_ADDR_W-1:0] rs1_addr,
    input  logic [`RV_REG_ADDR_W-1:0] rs2_addr,
    output logic [`RV_XLEN-1:0]       rs1_data,
    output logic [`RV_XLEN-1:0]       rs2_data
);

    logic [`RV_XLEN-1:0] regs [0:(1<<`RV_REG_ADDR_W)-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < (1 << `RV_REG_ADDR_W); k++) begin
                regs[k] <= '0;
            end
        end else if (we && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Write-through bypass, x0 hardwired to zero
    assign rs1_data = (rs1_addr == '0) ? '0 :
                      (we && wr_addr == rs1_addr) ? wr_data : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 :
                      (we && wr_addr == rs2_addr) ? wr_data : regs[rs2_addr];

endmodule

`default_nettype wire

//--- src/decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_params.svh"

module decoder (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              id_valid,
    input  logic [`RV_XLEN-1:0]               id_pc,
    input  logic [`RV_XLEN-1:0]               id_pc4,
    input  logic [`RV_XLEN-1:0]               id_ir,
    output logic [`RV_REG_ADDR_W-1:0]         rs1_addr,
    output logic [`RV_REG_ADDR_W-1:0]         rs2_addr,
    input  logic [`RV_XLEN-1:0]               rs1_data,
    input  logic [`RV_XLEN-1:0]               rs2_data,
    output logic [`RV_XLEN-1:0]               ex_pc,
    output logic [`RV_XLEN-1:0]               ex_pc4,
    output logic [`RV_XLEN-1:0]               ex_a,
    output logic [`RV_XLEN-1:0]               ex_b,
    output logic [`RV_XLEN-1:0]               ex_imm,
    output logic [rv_pipe_pkg::ALU_OP_W-1:0]  ex_alu_op,
    output logic                              ex_use_imm,
    output logic                              ex_use_pc,
    output logic                              ex_branch,
    output logic                              ex_jump,
    output logic                              ex_jalr,
    output logic [2:0]                        ex_funct3,
    output logic                              ex_load,
    output logic                              ex_store,
    output logic                              ex_reg_write,
    output logic [rv_pipe_pkg::WB_SEL_W-1:0]  ex_wb_sel,
    output logic [`RV_REG_ADDR_W-1:0]         ex_rd
);

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    rv_instr_u             instr;
    logic [`RV_XLEN-1:0]   imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [`RV_XLEN-1:0]   imm;
    logic [ALU_OP_W-1:0]   alu_op;
    logic [WB_SEL_W-1:0]   wb_sel;
    logic                  use_imm, use_pc, branch, jump, jalr, load, store, reg_write;

    // alt selects SUB or SRA
    function automatic logic [ALU_OP_W-1:0] alu_code(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  alu_code = alt ? ALU_SUB : ALU_ADD;
            3'b001:  alu_code = ALU_SLL;
            3'b010:  alu_code = ALU_SLT;
            3'b011:  alu_code = ALU_SLTU;
            3'b100:  alu_code = ALU_XOR;
            3'b101:  alu_code = alt ? ALU_SRA : ALU_SRL;
            3'b110:  alu_code = ALU_OR;
            default: alu_code = ALU_AND;
        endcase
    endfunction

    assign instr    = id_ir;
    assign rs1_addr = instr.r.rs1;
    assign rs2_addr = instr.r.rs2;

    assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
    assign imm_s = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
    assign imm_b = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                    instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
    assign imm_u = {instr.u.imm_31_12, 12'b0};
    assign imm_j = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                    instr.j.imm_11, instr.j.imm_10_1, 1'b0};

    always_comb begin
        imm       = imm_i;
        alu_op    = ALU_ADD;
        wb_sel    = WB_ALU;
        use_imm   = 1'b0;
        use_pc    = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        jalr      = 1'b0;
        load      = 1'b0;
        store     = 1'b0;
        reg_write = 1'b0;
        case (instr.r.opcode)
            OP_LUI: begin
                imm       = imm_u;
                alu_op    = ALU_PASS_B;
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            OP_AUIPC: begin
                imm       = imm_u;
                use_imm   = 1'b1;
                use_pc    = 1'b1;
                reg_write = 1'b1;
            end
            OP_JAL: begin
                imm       = imm_j;
                jump      = 1'b1;
                wb_sel    = WB_PC4;
                reg_write = 1'b1;
            end
            OP_JALR: begin
                jump      = 1'b1;
                jalr      = 1'b1;
                wb_sel    = WB_PC4;
                reg_write = 1'b1;
            end
            OP_BRANCH: begin
                imm    = imm_b;
                branch = 1'b1;
            end
            OP_LOAD: begin
                use_imm   = 1'b1;
                load      = 1'b1;
                wb_sel    = WB_MEM;
                reg_write = 1'b1;
            end
            OP_STORE: begin
                imm     = imm_s;
                use_imm = 1'b1;
                store   = 1'b1;
            end
            OP_IMM: begin
                // Only the shift-right form carries funct7
                alu_op    = alu_code(instr.r.funct3,
                                     instr.r.funct3 == 3'b101 && instr.r.funct7[5]);
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            OP_REG: begin
                alu_op    = alu_code(instr.r.funct3, instr.r.funct7[5]);
                reg_write = 1'b1;
            end
            default: ; // Unknown opcode stays a bubble
        endcase
    end

    // ID/EX control
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_use_imm   <= 1'b0;
            ex_use_pc    <= 1'b0;
            ex_branch    <= 1'b0;
            ex_jump      <= 1'b0;
            ex_jalr      <= 1'b0;
            ex_load      <= 1'b0;
            ex_store     <= 1'b0;
            ex_reg_write <= 1'b0;
            ex_wb_sel    <= WB_ALU;
            ex_alu_op    <= ALU_ADD;
        end else begin
            ex_use_imm   <= id_valid & use_imm;
            ex_use_pc    <= id_valid & use_pc;
            ex_branch    <= id_valid & branch;
            ex_jump      <= id_valid & jump;
            ex_jalr      <= id_valid & jalr;
            ex_load      <= id_valid & load;
            ex_store     <= id_valid & store;
            ex_reg_write <= id_valid & reg_write;
            ex_wb_sel    <= wb_sel;
            ex_alu_op    <= alu_op;
        end
    end

    // ID/EX payload
    always_ff @(posedge clk) begin
        ex_pc     <= id_pc;
        ex_pc4    <= id_pc4;
        ex_a      <= rs1_data;
        ex_b      <= rs2_data;
        ex_imm    <= imm;
        ex_funct3 <= instr.r.funct3;
        ex_rd     <= instr.r.rd;
    end

endmodule

`default_nettype wire

//--- src/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_params.svh"

module fetch_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                redirect,
    input  logic [`RV_XLEN-1:0] target,
    input  logic [`RV_XLEN-1:0] idt,
    output logic [`RV_XLEN-1:0] iad,
    output logic [`RV_XLEN-1:0] id_pc,
    output logic [`RV_XLEN-1:0] id_pc4,
    output logic [`RV_XLEN-1:0] id_ir,
    output logic                id_valid
);

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] pc4;

    assign pc4 = pc + `RV_XLEN'd4;
    assign iad = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= `RV_RESET_PC;
            id_valid <= 1'b0;
        end else begin
            pc       <= redirect ? target : pc4;
            id_valid <= 1'b1;
        end
    end

    // IF/ID
    always_ff @(posedge clk) begin
        id_pc  <= pc;
        id_pc4 <= pc4;
        id_ir  <= idt;
    end

endmodule

`default_nettype wire

//--- src/rv_pipe_pkg.sv
`default_nettype none

package rv_pipe_pkg;

    localparam int ALU_OP_W = 4;
    localparam int WB_SEL_W = 2;

    localparam logic [ALU_OP_W-1:0] ALU_ADD    = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB    = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_SLL    = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_SLT    = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU   = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_XOR    = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SRL    = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SRA    = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_OR     = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_AND    = 4'd9;
    localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 4'd10; // LUI

    localparam logic [WB_SEL_W-1:0] WB_ALU = 2'd0;
    localparam logic [WB_SEL_W-1:0] WB_MEM = 2'd1;
    localparam logic [WB_SEL_W-1:0] WB_PC4 = 2'd2; // Link address

endpackage

`default_nettype wire

//--- src/rv_isa_pkg.sv
`default_nettype none

`include "rv_params.svh"

package rv_isa_pkg;

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    // Branch conditions in funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef struct packed {
        logic [6:0]                funct7;
        logic [`RV_REG_ADDR_W-1:0] rs2;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [2:0]                funct3;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [6:0]                opcode;
    } rv_r_t;

    typedef struct packed {
        logic [11:0]               imm;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [2:0]                funct3;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [6:0]                opcode;
    } rv_i_t;

    typedef struct packed {
        logic [6:0]                imm_11_5;
        logic [`RV_REG_ADDR_W-1:0] rs2;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [2:0]                funct3;
        logic [4:0]                imm_4_0;
        logic [6:0]                opcode;
    } rv_s_t;

    typedef struct packed {
        logic                      imm_12;
        logic [5:0]                imm_10_5;
        logic [`RV_REG_ADDR_W-1:0] rs2;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [2:0]                funct3;
        logic [3:0]                imm_4_1;
        logic                      imm_11;
        logic [6:0]                opcode;
    } rv_b_t;

    typedef struct packed {
        logic [19:0]               imm_31_12;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [6:0]                opcode;
    } rv_u_t;

    typedef struct packed {
        logic                      imm_20;
        logic [9:0]                imm_10_1;
        logic                      imm_11;
        logic [7:0]                imm_19_12;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [6:0]                opcode;
    } rv_j_t;

    // One instruction word, every format overlaid
    typedef union packed {
        rv_r_t r;
        rv_i_t i;
        rv_s_t s;
        rv_b_t b;
        rv_u_t u;
        rv_j_t j;
    } rv_instr_u;

endpackage

`default_nettype wire

//--- src/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Data path width
`define RV_XLEN 32

// Register index width, 32 architectural registers
`define RV_REG_ADDR_W 5

`define RV_RESET_PC 32'h0001_0000

`endif
